// ==== rtl/game_pkg.sv ====
/*
 * Game-flow types shared by the shot controller, the top level and the testbench.
 * Also holds the default length of the result hold.
 */
package game_pkg;

    // phase of the whole game, driven from outside
    typedef enum logic [1:0] {
        MENU,
        SHOOTER,
        KEEPER,
        OVER
    } g_state;

    // phase of one shooter round
    typedef enum logic [2:0] {
        IDLE,
        ENGAGE,     // one cycle to confirm the shooter phase
        COUNTDOWN,  // armed, waiting for the click
        RESULT,
        GOAL,
        MISS,
        TERMINATE
    } shoot_state;

    typedef logic [25:0] hold_cnt_t;

    // roughly a quarter second at 50 MHz
    localparam hold_cnt_t hold_default = 26'd13003901;

endpackage

// ==== rtl/draw_pkg.sv ====
/*
 * Screen geometry, goal and keeper rectangles, colours and the keeper tint request.
 * in_box is used both for judging clicks and for painting pixels.
 */
package draw_pkg;

    typedef logic [11:0] coord_t;  // mouse position
    typedef logic [10:0] count_t;  // raster position
    typedef logic [11:0] rgb_t;    // 4 bits per channel

    typedef enum logic [1:0] {
        TINT_NONE,
        TINT_BLUE,
        TINT_GREEN,
        TINT_RED
    } keeper_tint_t;

    localparam coord_t screen_width = 12'd1024;

    // goal mouth, symmetric about the screen centre
    localparam coord_t post_inner_edge = 12'd212;
    localparam coord_t goal_right      = screen_width - post_inner_edge;
    localparam coord_t crossbar_bottom = 12'd200;
    localparam coord_t post_bottom     = 12'd600;

    // fixed keeper box
    localparam coord_t gk_left     = 12'd400;
    localparam coord_t gk_right    = 12'd600;
    localparam coord_t gk_top_y    = 12'd250;
    localparam coord_t gk_bottom_y = 12'd550;

    localparam rgb_t col_blue  = 12'h00F;
    localparam rgb_t col_green = 12'h0F0;
    localparam rgb_t col_red   = 12'hF00;

    // bounds inclusive on all four sides
    function automatic logic in_box(
        input coord_t x,
        input coord_t y,
        input coord_t x_lo,
        input coord_t x_hi,
        input coord_t y_lo,
        input coord_t y_hi
    );
        return (x >= x_lo) && (x <= x_hi) && (y >= y_lo) && (y <= y_hi);
    endfunction

endpackage

// ==== rtl/vga_if.sv ====
/*
 * Free-running VGA pixel stream, one pixel per clock and no back-pressure.
 * The producer takes the out modport and the consumer the in modport.
 */
interface vga_if import draw_pkg::*; ();

    count_t hcount;
    count_t vcount;
    logic   hsync;
    logic   vsync;
    logic   hblnk;
    logic   vblnk;
    rgb_t   rgb;

    modport in (
        input hcount, vcount,
        input hsync, vsync,
        input hblnk, vblnk,
        input rgb
    );

    modport out (
        output hcount, vcount,
        output hsync, vsync,
        output hblnk, vblnk,
        output rgb
    );

endinterface

// ==== rtl/shot_fsm.sv ====
/*
 * Round controller for the shooter. Arms on the shooter phase, judges one click,
 * holds the outcome for hold_cycles + 1 cycles and then closes the round.
 */
module shot_fsm import game_pkg::*, draw_pkg::*; #(
    parameter hold_cnt_t hold_cycles = hold_default
) (
    input  logic         clk,
    input  logic         rst,
    input  g_state       game_state,
    input  logic         left_clicked,
    input  coord_t       xpos,
    input  coord_t       ypos,
    output logic         is_scored,
    output logic         round_done,
    output logic         end_sh,
    output keeper_tint_t keeper_tint
);

    shoot_state   state;
    shoot_state   state_nxt;
    hold_cnt_t    hold_cnt;
    hold_cnt_t    hold_cnt_nxt;
    keeper_tint_t tint_nxt;
    logic         hold_last;
    logic         shot_on_goal;

    assign hold_last = (hold_cnt == hold_cycles);

    // inside the mouth but past the keeper
    assign shot_on_goal =
        in_box(xpos, ypos, post_inner_edge, goal_right, crossbar_bottom, post_bottom) &&
        !in_box(xpos, ypos, gk_left, gk_right, gk_top_y, gk_bottom_y);

    always_comb begin
        state_nxt    = state;
        hold_cnt_nxt = '0;
        case (state)
            IDLE: begin
                if (game_state == SHOOTER) begin
                    state_nxt = ENGAGE;
                end
            end
            ENGAGE: begin
                // drop back if the phase was only a glitch
                if (game_state == SHOOTER) begin
                    state_nxt = COUNTDOWN;
                end else begin
                    state_nxt = IDLE;
                end
            end
            COUNTDOWN: begin
                if (left_clicked) begin
                    state_nxt = RESULT;
                end
            end
            RESULT: begin
                if (shot_on_goal) begin
                    state_nxt = GOAL;
                end else begin
                    state_nxt = MISS;
                end
            end
            GOAL, MISS: begin
                if (hold_last) begin
                    state_nxt = TERMINATE;
                end else begin
                    hold_cnt_nxt = hold_cnt + 26'd1;
                end
            end
            TERMINATE: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_comb begin
        case (state)
            COUNTDOWN, RESULT: tint_nxt = TINT_BLUE;
            GOAL:              tint_nxt = TINT_GREEN;
            MISS:              tint_nxt = TINT_RED;
            default:           tint_nxt = TINT_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            hold_cnt <= '0;
        end else begin
            state    <= state_nxt;
            hold_cnt <= hold_cnt_nxt;
        end
    end

    // round outputs trail the state by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            is_scored   <= 1'b0;
            round_done  <= 1'b0;
            end_sh      <= 1'b0;
            keeper_tint <= TINT_NONE;
        end else begin
            is_scored   <= (state == GOAL);
            round_done  <= ((state == GOAL) || (state == MISS)) && hold_last;  // last hold cycle
            end_sh      <= (state == TERMINATE);
            keeper_tint <= tint_nxt;
        end
    end

endmodule

// ==== rtl/keeper_overlay.sv ====
/*
 * Paints the keeper box into the passing pixel stream in the colour asked for
 * by the round controller. Every signal goes through one register stage.
 */
module keeper_overlay import draw_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  keeper_tint_t keeper_tint,
    vga_if.in            vin,
    vga_if.out           vout
);

    rgb_t tint_rgb;
    rgb_t rgb_nxt;
    logic in_keeper;

    assign in_keeper = in_box(coord_t'(vin.hcount), coord_t'(vin.vcount),
                              gk_left, gk_right, gk_top_y, gk_bottom_y);

    always_comb begin
        case (keeper_tint)
            TINT_BLUE:  tint_rgb = col_blue;
            TINT_GREEN: tint_rgb = col_green;
            TINT_RED:   tint_rgb = col_red;
            default:    tint_rgb = vin.rgb;  // no box drawn
        endcase
    end

    assign rgb_nxt = in_keeper ? tint_rgb : vin.rgb;

    // timing and colour share the same stage so they stay aligned
    always_ff @(posedge clk) begin
        if (rst) begin
            vout.hcount <= '0;
            vout.vcount <= '0;
            vout.hsync  <= 1'b0;
            vout.vsync  <= 1'b0;
            vout.hblnk  <= 1'b0;
            vout.vblnk  <= 1'b0;
            vout.rgb    <= '0;
        end else begin
            vout.hcount <= vin.hcount;
            vout.vcount <= vin.vcount;
            vout.hsync  <= vin.hsync;
            vout.vsync  <= vin.vsync;
            vout.hblnk  <= vin.hblnk;
            vout.vblnk  <= vin.vblnk;
            vout.rgb    <= rgb_nxt;
        end
    end

endmodule

// ==== rtl/penalty_shooter_top.sv ====
/*
 * Shooter side of the penalty game in solo mode: round controller plus keeper overlay.
 * The video stream passes through with one cycle of latency.
 */
module penalty_shooter_top import game_pkg::*, draw_pkg::*; #(
    parameter hold_cnt_t hold_cycles = hold_default
) (
    input  logic   clk,
    input  logic   rst,
    input  g_state game_state,
    input  logic   left_clicked,
    input  coord_t xpos,
    input  coord_t ypos,

    input  count_t hcount_in,
    input  count_t vcount_in,
    input  logic   hsync_in,
    input  logic   vsync_in,
    input  logic   hblnk_in,
    input  logic   vblnk_in,
    input  rgb_t   rgb_in,

    output count_t hcount_out,
    output count_t vcount_out,
    output logic   hsync_out,
    output logic   vsync_out,
    output logic   hblnk_out,
    output logic   vblnk_out,
    output rgb_t   rgb_out,

    output logic   is_scored,
    output logic   round_done,
    output logic   end_sh
);

    keeper_tint_t keeper_tint;

    vga_if vga_in ();
    vga_if vga_out ();

    assign vga_in.hcount = hcount_in;
    assign vga_in.vcount = vcount_in;
    assign vga_in.hsync  = hsync_in;
    assign vga_in.vsync  = vsync_in;
    assign vga_in.hblnk  = hblnk_in;
    assign vga_in.vblnk  = vblnk_in;
    assign vga_in.rgb    = rgb_in;

    assign hcount_out = vga_out.hcount;
    assign vcount_out = vga_out.vcount;
    assign hsync_out  = vga_out.hsync;
    assign vsync_out  = vga_out.vsync;
    assign hblnk_out  = vga_out.hblnk;
    assign vblnk_out  = vga_out.vblnk;
    assign rgb_out    = vga_out.rgb;

    shot_fsm #(
        .hold_cycles(hold_cycles)
    ) shot_fsm_inst (
        .clk,
        .rst,
        .game_state,
        .left_clicked,
        .xpos,
        .ypos,
        .is_scored,
        .round_done,
        .end_sh,
        .keeper_tint
    );

    keeper_overlay keeper_overlay_inst (
        .clk,
        .rst,
        .keeper_tint,
        .vin  (vga_in.in),
        .vout (vga_out.out)
    );

endmodule

// ==== dv/tb_clock_gen.sv ====
/*
 * Clock and reset source for the testbench, reset released just after an edge.
 */
module tb_clock_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #2 rst = 1'b0;  // same skew as the stimulus
    end

endmodule

// ==== dv/shooter_assert.sv ====
/*
 * Protocol checks on the round outputs of the shooter top level, attached by bind.
 */
module shooter_assert (
    input logic clk,
    input logic rst,
    input logic is_scored,
    input logic round_done,
    input logic end_sh
);
    timeunit 1ns;
    timeprecision 1ps;

    // round close is a single-cycle pulse
    done_single: assert property (@(posedge clk) disable iff (rst)
        round_done |=> !round_done)
        else $error("round_done stayed high for more than one cycle");

    end_after_done: assert property (@(posedge clk) disable iff (rst)
        round_done |=> end_sh)
        else $error("end_sh missing in the cycle after round_done");

    end_needs_done: assert property (@(posedge clk) disable iff (rst)
        end_sh |-> $past(round_done))
        else $error("end_sh pulsed without round_done one cycle before");

    no_overlap: assert property (@(posedge clk) disable iff (rst)
        !(is_scored && end_sh))
        else $error("is_scored and end_sh high in the same cycle");

endmodule

bind penalty_shooter_top shooter_assert shooter_assert_inst (
    .clk,
    .rst,
    .is_scored,
    .round_done,
    .end_sh
);

// ==== dv/tb_penalty_shooter.sv ====
/*
 * Testbench for the shooter top level. Sweeps a raster, plays random rounds and
 * compares every output each cycle with a cycle-level model of the round rules.
 */
module tb_penalty_shooter import game_pkg::*, draw_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int hold_cycles = 20;
    localparam int n_rounds    = 30;
    localparam int timeout_ns  = 2 * n_rounds * (hold_cycles + 60) * 20;
    localparam int h_total     = 1344;
    localparam int v_total     = 806;

    logic   clk;
    logic   rst;
    g_state game_state;
    logic   left_clicked;
    coord_t xpos;
    coord_t ypos;
    count_t hcount_in;
    count_t vcount_in;
    logic   hsync_in, vsync_in, hblnk_in, vblnk_in;
    rgb_t   rgb_in;
    count_t hcount_out;
    count_t vcount_out;
    logic   hsync_out, vsync_out, hblnk_out, vblnk_out;
    rgb_t   rgb_out;
    logic   is_scored, round_done, end_sh;

    logic [31:0] rng = 32'hdd60_7dd9;
    int h_pos;
    int v_pos;
    int value_errors;
    int seq_errors;
    int n_blue;   // painted keeper pixels per colour
    int n_green;
    int n_red;
    int n_painted;  // pixels the DUT changed on the way through

    // model state and expected outputs
    shoot_state   m_state;
    int           m_hold;
    logic         m_scored, m_done, m_end;
    keeper_tint_t m_tint;
    count_t       e_hcount;
    count_t       e_vcount;
    logic         e_hsync, e_vsync, e_hblnk, e_vblnk;
    rgb_t         e_rgb;

    tb_clock_gen #(.period_ns(20), .reset_cycles(2)) clock_gen_inst (.clk, .rst);

    penalty_shooter_top #(
        .hold_cycles(hold_cnt_t'(hold_cycles))
    ) penalty_shooter_top_inst (.*);

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(next_rand() % (hi - lo + 1));
    endfunction

    function automatic logic point_in_rect(input coord_t x, input coord_t y, input coord_t x0,
                                           input coord_t x1, input coord_t y0, input coord_t y1);
        return (x >= x0) && (x <= x1) && (y >= y0) && (y <= y1);
    endfunction

    // goal: inside the mouth, outside the keeper
    function automatic logic shot_scores(input coord_t x, input coord_t y);
        return point_in_rect(x, y, post_inner_edge, goal_right, crossbar_bottom, post_bottom) &&
               !point_in_rect(x, y, gk_left, gk_right, gk_top_y, gk_bottom_y);
    endfunction

    function automatic keeper_tint_t tint_for(input shoot_state s);
        case (s)
            COUNTDOWN, RESULT: return TINT_BLUE;
            GOAL:              return TINT_GREEN;
            MISS:              return TINT_RED;
            default:           return TINT_NONE;
        endcase
    endfunction

    function automatic rgb_t tint_colour(input keeper_tint_t t);
        case (t)
            TINT_BLUE:  return col_blue;
            TINT_GREEN: return col_green;
            default:    return col_red;
        endcase
    endfunction

    function automatic g_state idle_phase();
        case (rand_range(0, 2))
            0:       return MENU;
            1:       return KEEPER;
            default: return OVER;
        endcase
    endfunction

    // compressed raster, strides chosen so the keeper box is crossed often
    function automatic void drive_raster();
        h_pos = h_pos + 61;
        if (h_pos >= h_total) begin
            h_pos = h_pos - h_total;
            v_pos = (v_pos + 17) % v_total;
        end
        hcount_in = count_t'(h_pos);
        vcount_in = count_t'(v_pos);
        hblnk_in  = (h_pos >= 1024);
        hsync_in  = (h_pos >= 1048) && (h_pos < 1184);
        vblnk_in  = (v_pos >= 768);
        vsync_in  = (v_pos >= 771) && (v_pos < 777);
        rgb_in    = rgb_t'(next_rand());
    endfunction

    // one clock edge of the model, outputs taken from the old state
    function automatic void model_step();
        logic in_gk;
        in_gk = point_in_rect(coord_t'(hcount_in), coord_t'(vcount_in),
                              gk_left, gk_right, gk_top_y, gk_bottom_y);
        if (rst) begin
            m_state  = IDLE;
            m_hold   = 0;
            m_scored = 1'b0;
            m_done   = 1'b0;
            m_end    = 1'b0;
            m_tint   = TINT_NONE;
            e_hcount = '0;
            e_vcount = '0;
            {e_hsync, e_vsync, e_hblnk, e_vblnk} = 4'b0000;
            e_rgb    = '0;
        end else begin
            e_hcount = hcount_in;
            e_vcount = vcount_in;
            {e_hsync, e_vsync, e_hblnk, e_vblnk} = {hsync_in, vsync_in, hblnk_in, vblnk_in};
            if (in_gk && (m_tint != TINT_NONE)) begin
                e_rgb = tint_colour(m_tint);
                n_blue  += (m_tint == TINT_BLUE) ? 1 : 0;
                n_green += (m_tint == TINT_GREEN) ? 1 : 0;
                n_red   += (m_tint == TINT_RED) ? 1 : 0;
            end else begin
                e_rgb = rgb_in;
            end
            m_scored = (m_state == GOAL);
            m_done   = ((m_state == GOAL) || (m_state == MISS)) && (m_hold == 0);
            m_end    = (m_state == TERMINATE);
            m_tint   = tint_for(m_state);
            case (m_state)
                IDLE:      m_state = (game_state == SHOOTER) ? ENGAGE : IDLE;
                ENGAGE:    m_state = (game_state == SHOOTER) ? COUNTDOWN : IDLE;
                COUNTDOWN: m_state = left_clicked ? RESULT : COUNTDOWN;
                RESULT: begin
                    m_hold  = hold_cycles;  // hold lasts hold_cycles + 1
                    m_state = shot_scores(xpos, ypos) ? GOAL : MISS;
                end
                GOAL, MISS: begin
                    if (m_hold == 0) begin
                        m_state = TERMINATE;
                    end else begin
                        m_hold--;
                    end
                end
                default:   m_state = IDLE;
            endcase
        end
    endfunction

    task automatic check_pixel(input string name, input rgb_t got, input rgb_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_state_seq(input logic ok, input string what);
        if (!ok) begin
            seq_errors++;
            $display("Error at %0d ns: %s", $time, what);
        end
    endtask

    task automatic compare_outputs();
        check_count("hcount_out", hcount_out, e_hcount);
        check_count("vcount_out", vcount_out, e_vcount);
        check_flag("hsync_out", hsync_out, e_hsync);
        check_flag("vsync_out", vsync_out, e_vsync);
        check_flag("hblnk_out", hblnk_out, e_hblnk);
        check_flag("vblnk_out", vblnk_out, e_vblnk);
        check_pixel("rgb_out", rgb_out, e_rgb);
        check_flag("is_scored", is_scored, m_scored);
        check_flag("round_done", round_done, m_done);
        check_flag("end_sh", end_sh, m_end);
    endtask

    // model at the edge, compare once settled, then drive
    task automatic tick();
        @(posedge clk);
        model_step();
        #1;
        compare_outputs();
        // rgb_in still holds the pixel just registered
        if (!rst && (rgb_out !== rgb_in)) begin
            n_painted++;
        end
        #1;
        drive_raster();
    endtask

    task automatic run_round();
        coord_t cx;
        coord_t cy;
        logic   goal;
        int     waited;
        int     scored_len;
        game_state = idle_phase();
        repeat (rand_range(2, 9)) tick();
        game_state = SHOOTER;
        repeat (rand_range(3, 15)) tick();  // engage, then armed in blue
        cx = coord_t'(rand_range(150, 873));
        cy = coord_t'(rand_range(150, 649));
        goal = shot_scores(cx, cy);
        xpos = cx;
        ypos = cy;
        left_clicked = 1'b1;
        tick();
        left_clicked = 1'b0;
        game_state = KEEPER;
        waited = 0;
        scored_len = 0;
        while ((round_done !== 1'b1) && (waited < hold_cycles + 10)) begin
            tick();
            waited++;
            scored_len += (is_scored === 1'b1) ? 1 : 0;
        end
        check_state_seq(round_done === 1'b1, "round_done never pulsed after the shot");
        check_state_seq(scored_len == (goal ? hold_cycles + 1 : 0),
                        $sformatf("is_scored high for %0d cycles on a %s at (%0d, %0d)",
                                  scored_len, goal ? "goal" : "miss", cx, cy));
        tick();
        check_state_seq((round_done === 1'b0) && (end_sh === 1'b1),
                        "end_sh did not pulse in the cycle after round_done");
    endtask

    task automatic abort_arming();
        int painted_before;
        int outputs_seen;
        game_state = MENU;
        repeat (4) tick();
        painted_before = n_painted;
        outputs_seen = 0;
        game_state = SHOOTER;
        tick();
        game_state = MENU;  // gone again after one cycle
        repeat (40) begin
            xpos = coord_t'(rand_range(150, 873));
            ypos = coord_t'(rand_range(150, 649));
            left_clicked = (rand_range(0, 3) == 0);
            tick();
            outputs_seen += (is_scored || round_done || end_sh) ? 1 : 0;
        end
        left_clicked = 1'b0;
        check_state_seq(n_painted == painted_before,
                        "keeper box drawn after an aborted arming");
        check_state_seq(outputs_seen == 0, "round output rose after an aborted arming");
    endtask

    initial begin
        game_state   = MENU;
        left_clicked = 1'b0;
        xpos         = '0;
        ypos         = '0;
        drive_raster();
        repeat (3) tick();
        repeat (150) begin
            game_state = idle_phase();
            tick();
        end
        check_state_seq(n_painted == 0, "keeper box drawn outside a round");
        for (int r = 0; r < n_rounds; r++) begin
            run_round();
        end
        abort_arming();
        check_state_seq(n_blue > 0, "no keeper pixel was ever painted blue");
        check_state_seq(n_green > 0, "no keeper pixel was ever painted green");
        check_state_seq(n_red > 0, "no keeper pixel was ever painted red");
        $display("run complete: %0d value errors, %0d sequence errors",
                 value_errors, seq_errors);
        if (value_errors + seq_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Watchdog expired after %0d ns, the run did not finish", timeout_ns);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
rtl/game_pkg.sv
rtl/draw_pkg.sv
rtl/vga_if.sv
rtl/shot_fsm.sv
rtl/keeper_overlay.sv
rtl/penalty_shooter_top.sv
dv/tb_clock_gen.sv
dv/shooter_assert.sv
dv/tb_penalty_shooter.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the shooter testbench with Verilator, runs it and judges the log.
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_penalty_shooter -f filelist.f --Mdir "$build_dir" -o sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$build_dir/sim" +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if grep -q "SOME TESTS FAILED" "$log"; then
    echo "result: FAIL"
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$log"; then
    echo "result: FAIL, run ended without a verdict"
    exit 1
fi
echo "result: PASS"
exit 0
